//--- common/qspinor_bus_pkg.sv
package qspinor_bus_pkg;

    localparam int BUS_W = 32;

    typedef enum logic [1:0] {
        ACC_1B = 2'd0,
        ACC_2B = 2'd1,
        ACC_4B = 2'd2
    } bus_acc_t;

    // misaligned halfword or word, or any write into flash space
    function automatic logic bus_fault(input logic [1:0] addr_lo, input bus_acc_t acc,
                                       input logic w_rb);
        logic misalign;
        misalign = (addr_lo[0] && acc != ACC_1B) || (addr_lo == 2'd2 && acc == ACC_4B);
        return misalign || w_rb;
    endfunction

    // byte lane of the last byte in an access
    function automatic logic [1:0] acc_last(input bus_acc_t acc);
        case (acc)
            ACC_4B: return 2'd3;
            ACC_2B: return 2'd1;
            default: return 2'd0;
        endcase
    endfunction

endpackage

//--- common/qspinor_phy_pkg.sv
package qspinor_phy_pkg;

    typedef enum logic [1:0] {
        LANE_X1 = 2'd0,
        LANE_X2 = 2'd1,
        LANE_X4 = 2'd2
    } lane_w_t;

    // lane modes, named by cmd / addr / data width
    localparam logic [2:0] MODE_111 = 3'd0;
    localparam logic [2:0] MODE_112 = 3'd1;
    localparam logic [2:0] MODE_114 = 3'd2;
    localparam logic [2:0] MODE_122 = 3'd3;
    localparam logic [2:0] MODE_144 = 3'd4;
    localparam logic [2:0] MODE_222 = 3'd5;
    localparam logic [2:0] MODE_444 = 3'd6;

    // configuration word layout
    localparam int CFG_W        = 16;
    localparam int CFG_CMD_LSB  = 8;
    localparam int CFG_CMD_W    = 8;
    localparam int CFG_DCNT_LSB = 4;
    localparam int CFG_DCNT_W   = 4;
    localparam int CFG_DDIR_BIT = 3;
    localparam int CFG_MODE_LSB = 0;
    localparam int CFG_MODE_W   = 3;

endpackage

//--- logic/qspinor_mode_csr.sv
module qspinor_mode_csr
    import qspinor_phy_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  csr_we,
    input  logic [CFG_W-1:0]      csr_wdata,
    output logic [CFG_W-1:0]      csr_rdata,
    output lane_w_t               cmd_w,
    output lane_w_t               addr_w,
    output lane_w_t               data_w,
    output logic [CFG_CMD_W-1:0]  cmd_octet,
    output logic [CFG_DCNT_W-1:0] dmy_cnt,
    output logic                  dmy_dir
);

    logic [CFG_W-1:0]      cfg;
    logic [CFG_MODE_W-1:0] mode;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cfg <= '0;
        end else if (csr_we) begin
            cfg <= csr_wdata;
        end
    end

    assign csr_rdata = cfg;
    assign mode      = cfg[CFG_MODE_LSB +: CFG_MODE_W];
    assign cmd_octet = cfg[CFG_CMD_LSB +: CFG_CMD_W];
    assign dmy_cnt   = cfg[CFG_DCNT_LSB +: CFG_DCNT_W];
    assign dmy_dir   = cfg[CFG_DDIR_BIT];

    // mode 7 falls through to x1 everywhere
    assign cmd_w  = (mode == MODE_444) ? LANE_X4 :
                    (mode == MODE_222) ? LANE_X2 : LANE_X1;
    assign addr_w = (mode inside {MODE_144, MODE_444}) ? LANE_X4 :
                    (mode inside {MODE_122, MODE_222}) ? LANE_X2 : LANE_X1;
    assign data_w = (mode inside {MODE_114, MODE_144, MODE_444}) ? LANE_X4 :
                    (mode inside {MODE_112, MODE_122, MODE_222}) ? LANE_X2 : LANE_X1;

    a_mode_legal: assert property (@(posedge clk) disable iff (!rstn)
        csr_we |=> mode inside {[MODE_111:MODE_444]});

endmodule

//--- qspinor_read/qspinor_read_seq.sv
module qspinor_read_seq
    import qspinor_bus_pkg::*;
    import qspinor_phy_pkg::*;
#(
    parameter int VA_W = 24
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [VA_W-1:0]       addr,
    input  bus_acc_t              acc,
    input  logic                  w_rb,
    input  logic                  req,
    output logic [BUS_W-1:0]      rdata,
    output logic                  resp,
    output logic                  fault,
    input  lane_w_t               cmd_w,
    input  lane_w_t               addr_w,
    input  lane_w_t               data_w,
    input  logic [CFG_CMD_W-1:0]  cmd_octet,
    input  logic [CFG_DCNT_W-1:0] dmy_cnt,
    output lane_w_t               lane_w,
    output logic                  tx_req,
    output logic [7:0]            tx_byte,
    input  logic                  tx_resp,
    output logic                  rx_req,
    input  logic [7:0]            rx_byte,
    input  logic                  rx_resp,
    output logic                  dmy_req,
    input  logic                  dmy_resp,
    output logic                  csb
);

    typedef enum logic [2:0] {IDLE, PREP, CMD, ADDR, DMY, DATA} state_t;

    state_t      state, next_state;
    logic [3:0]  cnt, next_cnt;  // addr byte, dummy pulse or data byte
    logic        accept;
    logic [23:0] addr_q;
    bus_acc_t    acc_q;

    assign fault  = req && bus_fault(addr[1:0], acc, w_rb);
    assign accept = req && !fault && (state == IDLE);

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= 24'(addr);  // 3-byte address, upper bytes zero
            acc_q  <= acc;
        end
    end

    always_comb begin
        next_state = state;
        next_cnt   = cnt;
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = PREP;
                end
            end
            PREP: next_state = CMD;
            CMD: begin
                if (tx_resp) begin
                    next_state = ADDR;
                    next_cnt   = 4'd2;
                end
            end
            ADDR: begin
                if (tx_resp) begin
                    if (cnt != 4'd0) begin
                        next_cnt = cnt - 4'd1;
                    end else if (dmy_cnt != '0) begin
                        next_state = DMY;
                        next_cnt   = dmy_cnt;
                    end else begin
                        next_state = DATA;
                        next_cnt   = 4'd0;
                    end
                end
            end
            DMY: begin
                if (dmy_resp) begin
                    if (cnt != 4'd1) begin
                        next_cnt = cnt - 4'd1;
                    end else begin
                        next_state = DATA;
                        next_cnt   = 4'd0;
                    end
                end
            end
            DATA: begin
                if (rx_resp) begin
                    if (cnt[1:0] == acc_last(acc_q)) begin
                        next_state = IDLE;
                        next_cnt   = 4'd0;
                    end else begin
                        next_cnt = cnt + 4'd1;
                    end
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // requests go out in the resp cycle so bytes run back to back
    always_comb begin
        lane_w  = LANE_X1;
        tx_req  = 1'b0;
        rx_req  = 1'b0;
        dmy_req = 1'b0;
        tx_byte = cmd_octet;
        case (next_state)
            CMD: begin
                lane_w = cmd_w;
                tx_req = (state == PREP);
            end
            ADDR: begin
                lane_w  = addr_w;
                tx_req  = tx_resp;
                tx_byte = addr_q[8*next_cnt[1:0] +: 8];  // msb first
            end
            DMY: begin
                lane_w  = addr_w;  // dummy width follows address
                dmy_req = tx_resp || dmy_resp;
            end
            DATA: begin
                lane_w = data_w;
                rx_req = tx_resp || dmy_resp || rx_resp;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            cnt   <= '0;
            resp  <= 1'b0;
            csb   <= 1'b1;
        end else begin
            state <= next_state;
            cnt   <= next_cnt;
            resp  <= (state == DATA) && (next_state == IDLE);
            if (accept) begin
                csb <= 1'b0;
            end else if (resp) begin
                csb <= 1'b1;
            end
        end
    end

    // little endian, byte n of the access in lane n
    always_ff @(posedge clk) begin
        if (state == DATA && rx_resp) begin
            rdata[8*cnt[1:0] +: 8] <= rx_byte;
        end
    end

    a_req_idle: assert property (@(posedge clk) disable iff (!rstn) req |-> csb);
    a_resp_no_fault: assert property (@(posedge clk) disable iff (!rstn) !(resp && fault));

endmodule

//--- logic/qspinor_shifter.sv
module qspinor_shifter
    import qspinor_phy_pkg::*;
#(
    parameter bit SCLK_IDLE = 1'b0
) (
    input  logic       clk,
    input  logic       rstn,
    input  lane_w_t    lane_w,
    input  logic       tx_req,
    input  logic [7:0] tx_byte,
    output logic       tx_resp,
    input  logic       rx_req,
    output logic [7:0] rx_byte,
    output logic       rx_resp,
    input  logic       dmy_req,
    input  logic       dmy_dir,
    output logic       dmy_resp,
    output logic       sclk,
    output logic [3:0] dir,
    output logic [3:0] mosi,
    input  logic [3:0] miso
);

    typedef enum logic [2:0] {IDLE, TX, RX, DMY_O, DMY_I} state_t;

    state_t     state, next_state;
    logic [3:0] cnt, next_cnt;
    logic [3:0] byte_cnt;
    lane_w_t    w_q;
    logic [7:0] tx_q;
    logic [3:0] lane_oe;

    // two clocks per bit slot
    assign byte_cnt = (lane_w == LANE_X1) ? 4'd15 : (lane_w == LANE_X2) ? 4'd7 : 4'd3;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            state <= next_state;
            cnt   <= next_cnt;
        end
    end

    always_comb begin
        next_state = state;
        next_cnt   = cnt - 4'd1;
        if (cnt == 4'd0) begin  // idle or last slot
            next_cnt = byte_cnt;
            if (tx_req) begin
                next_state = TX;
            end else if (rx_req) begin
                next_state = RX;
            end else if (dmy_req) begin
                next_state = dmy_dir ? DMY_O : DMY_I;
                next_cnt   = 4'd1;
            end else begin
                next_state = IDLE;
                next_cnt   = 4'd0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cnt == 4'd0 && (tx_req || rx_req || dmy_req)) begin
            w_q  <= lane_w;
            tx_q <= tx_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tx_resp  <= 1'b0;
            rx_resp  <= 1'b0;
            dmy_resp <= 1'b0;
        end else begin
            tx_resp  <= (state == TX) && (cnt == 4'd1);
            rx_resp  <= (state == RX) && (cnt == 4'd1);
            dmy_resp <= (state == DMY_O || state == DMY_I) && (cnt == 4'd1);
        end
    end

    assign sclk = (state == IDLE) ? SCLK_IDLE : ~cnt[0];

    always_comb begin
        case (w_q)
            LANE_X1: lane_oe = 4'b0001;
            LANE_X2: lane_oe = 4'b0011;
            default: lane_oe = 4'b1111;
        endcase
    end

    assign dir = (state == TX || state == DMY_O) ? lane_oe : 4'b0000;

    always_comb begin
        mosi = 4'b0000;  // also the dummy-out level
        if (state == TX) begin
            case (w_q)
                LANE_X1: mosi = {3'b000, tx_q[cnt[3:1]]};
                LANE_X2: mosi = {2'b00, tx_q[{cnt[2:1], 1'b0} +: 2]};
                default: mosi = tx_q[{cnt[1], 2'b00} +: 4];
            endcase
        end
    end

    // captured on the edge that raises sclk
    always_ff @(posedge clk) begin
        if (state == RX && cnt[0]) begin
            case (w_q)
                LANE_X1: rx_byte[cnt[3:1]] <= miso[1];
                LANE_X2: rx_byte[{cnt[2:1], 1'b0} +: 2] <= miso[1:0];
                default: rx_byte[{cnt[1], 2'b00} +: 4] <= miso;
            endcase
        end
    end

    a_one_req: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0({tx_req, rx_req, dmy_req}));

endmodule

//--- logic/qspinor_top.sv
module qspinor_top
    import qspinor_bus_pkg::*;
    import qspinor_phy_pkg::*;
#(
    parameter int VA_W      = 24,
    parameter bit SCLK_IDLE = 1'b0
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic [VA_W-1:0]  addr,
    input  bus_acc_t         acc,
    input  logic             w_rb,
    input  logic             req,
    output logic [BUS_W-1:0] rdata,
    output logic             resp,
    output logic             fault,
    input  logic             csr_we,
    input  logic [CFG_W-1:0] csr_wdata,
    output logic [CFG_W-1:0] csr_rdata,
    output logic             csb,
    output logic             sclk,
    output logic [3:0]       dir,
    output logic [3:0]       mosi,
    input  logic [3:0]       miso
);

    lane_w_t               cmd_w, addr_w, data_w, lane_w;
    logic [CFG_CMD_W-1:0]  cmd_octet;
    logic [CFG_DCNT_W-1:0] dmy_cnt;
    logic                  dmy_dir;
    logic                  tx_req, tx_resp, rx_req, rx_resp, dmy_req, dmy_resp;
    logic [7:0]            tx_byte, rx_byte;

    qspinor_mode_csr qspinor_mode_csr_i (
        .clk       (clk),
        .rstn      (rstn),
        .csr_we    (csr_we),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .cmd_w     (cmd_w),
        .addr_w    (addr_w),
        .data_w    (data_w),
        .cmd_octet (cmd_octet),
        .dmy_cnt   (dmy_cnt),
        .dmy_dir   (dmy_dir)
    );

    qspinor_read_seq #(.VA_W(VA_W)) qspinor_read_seq_i (
        .clk       (clk),
        .rstn      (rstn),
        .addr      (addr),
        .acc       (acc),
        .w_rb      (w_rb),
        .req       (req),
        .rdata     (rdata),
        .resp      (resp),
        .fault     (fault),
        .cmd_w     (cmd_w),
        .addr_w    (addr_w),
        .data_w    (data_w),
        .cmd_octet (cmd_octet),
        .dmy_cnt   (dmy_cnt),
        .lane_w    (lane_w),
        .tx_req    (tx_req),
        .tx_byte   (tx_byte),
        .tx_resp   (tx_resp),
        .rx_req    (rx_req),
        .rx_byte   (rx_byte),
        .rx_resp   (rx_resp),
        .dmy_req   (dmy_req),
        .dmy_resp  (dmy_resp),
        .csb       (csb)
    );

    qspinor_shifter #(.SCLK_IDLE(SCLK_IDLE)) qspinor_shifter_i (
        .clk      (clk),
        .rstn     (rstn),
        .lane_w   (lane_w),
        .tx_req   (tx_req),
        .tx_byte  (tx_byte),
        .tx_resp  (tx_resp),
        .rx_req   (rx_req),
        .rx_byte  (rx_byte),
        .rx_resp  (rx_resp),
        .dmy_req  (dmy_req),
        .dmy_dir  (dmy_dir),  // straight from the register
        .dmy_resp (dmy_resp),
        .sclk     (sclk),
        .dir      (dir),
        .mosi     (mosi),
        .miso     (miso)
    );

endmodule

//--- tests/qspinor_flash_model.sv
module qspinor_flash_model (
    input  logic       csb,
    input  logic       sclk,
    input  logic [3:0] mosi,
    input  logic [3:0] dir,
    output logic [3:0] miso,
    input  logic [2:0] mode,
    input  logic [3:0] dmy_cnt,
    input  logic [7:0] cmd,
    output logic       cmd_bad,
    output logic       dir_bad
);

    int          wc, wa, wd;  // lanes for command, address, data
    int          n_cmd, n_addr, n_pre;
    int          edges;       // rising sclk edges since select
    int          lanes;
    int          bitpos;
    logic [3:0]  bits;
    logic [7:0]  cmd_sr;
    logic [7:0]  d;
    logic [23:0] addr_sr;

    function automatic logic [7:0] pattern(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    assign wc = (mode == 3'd6) ? 4 : (mode == 3'd5) ? 2 : 1;
    assign wa = (mode == 3'd4 || mode == 3'd6) ? 4 : (mode == 3'd3 || mode == 3'd5) ? 2 : 1;
    assign wd = (mode == 3'd2 || mode == 3'd4 || mode == 3'd6) ? 4 : (mode == 3'd0) ? 1 : 2;

    assign n_cmd  = 8 / wc;
    assign n_addr = 24 / wa;
    assign n_pre  = n_cmd + n_addr + int'(dmy_cnt);  // one edge per dummy pulse

    initial begin
        miso    = 4'h0;
        cmd_bad = 1'b0;
        dir_bad = 1'b0;
        edges   = 0;
    end

    always @(negedge csb) begin
        edges   = 0;
        cmd_bad = 1'b0;
        dir_bad = 1'b0;
    end

    // command and address sampled on rising sclk
    always @(posedge sclk) begin
        if (csb == 1'b0) begin
            lanes = (edges < n_cmd) ? wc : wa;
            bits  = mosi & 4'((1 << lanes) - 1);
            // host drives just the active lanes, and none while data comes back
            if (edges < n_cmd + n_addr) begin
                if (dir != 4'((1 << lanes) - 1)) begin
                    dir_bad = 1'b1;
                end
            end else if (edges >= n_pre && dir != 4'b0000) begin
                dir_bad = 1'b1;
            end
            if (edges < n_cmd) begin
                cmd_sr = (cmd_sr << wc) | 8'(bits);
                if (edges == n_cmd - 1 && cmd_sr != cmd) begin
                    cmd_bad = 1'b1;
                end
            end else if (edges < n_cmd + n_addr) begin
                addr_sr = (addr_sr << wa) | 24'(bits);
            end
            edges = edges + 1;
        end
    end

    // next data bits go out after each falling sclk
    always @(negedge sclk) begin
        if (csb == 1'b0 && edges >= n_pre) begin
            bitpos = (edges - n_pre) * wd;
            d      = pattern(addr_sr + 24'(bitpos / 8));
            d      = d << (bitpos % 8);
            case (wd)
                1: miso <= {2'b00, d[7], 1'b0};  // x1 data on lane 1
                2: miso <= {2'b00, d[7:6]};
                default: miso <= d[7:4];
            endcase
        end
    end

endmodule

//--- tests/tb_qspinor.sv
module tb_qspinor
    import qspinor_bus_pkg::*;
();

    localparam int READ_LIMIT   = 1200;
    localparam int RESET_CYCLES = 16;
    localparam int MAX_CYCLES   = 80 * READ_LIMIT + RESET_CYCLES;

    logic        clk;
    logic        rstn;
    logic [23:0] addr;
    bus_acc_t    acc;
    logic        w_rb;
    logic        req;
    logic [31:0] rdata;
    logic        resp;
    logic        fault;
    logic        csr_we;
    logic [15:0] csr_wdata;
    logic [15:0] csr_rdata;
    logic        csb;
    logic        sclk;
    logic [3:0]  dir;
    logic [3:0]  mosi;
    logic [3:0]  miso;
    logic [2:0]  cfg_mode = 3'd0;
    logic [3:0]  cfg_dcnt = 4'd0;
    logic [7:0]  cfg_cmd  = 8'd0;
    logic        cmd_bad;
    logic        dir_bad;

    logic        exp_fault = 1'b0;
    logic [31:0] exp_rdata = '0;
    logic [31:0] exp_mask  = '0;
    logic        pending   = 1'b0;  // valid read waiting for resp
    logic        resp_q    = 1'b0;
    int          cycles    = 0;

    qspinor_top qspinor_top_i (
        .clk       (clk),
        .rstn      (rstn),
        .addr      (addr),
        .acc       (acc),
        .w_rb      (w_rb),
        .req       (req),
        .rdata     (rdata),
        .resp      (resp),
        .fault     (fault),
        .csr_we    (csr_we),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .csb       (csb),
        .sclk      (sclk),
        .dir       (dir),
        .mosi      (mosi),
        .miso      (miso)
    );

    qspinor_flash_model flash_model_i (
        .csb     (csb),
        .sclk    (sclk),
        .mosi    (mosi),
        .dir     (dir),
        .miso    (miso),
        .mode    (cfg_mode),
        .dmy_cnt (cfg_dcnt),
        .cmd     (cfg_cmd),
        .cmd_bad (cmd_bad),
        .dir_bad (dir_bad)
    );

    function automatic logic [7:0] pattern_byte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    function automatic int acc_bytes(input bus_acc_t ac);
        return (ac == ACC_4B) ? 4 : (ac == ACC_2B) ? 2 : 1;
    endfunction

    function automatic logic [31:0] byte_mask(input bus_acc_t ac);
        return (ac == ACC_4B) ? 32'hffff_ffff : (ac == ACC_2B) ? 32'h0000_ffff : 32'h0000_00ff;
    endfunction

    // byte at addr+i lands in lane i
    function automatic logic [31:0] expected_rdata(input logic [23:0] a, input bus_acc_t ac);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < acc_bytes(ac); i++) begin
            v[8*i +: 8] = pattern_byte(a + 24'(i));
        end
        return v;
    endfunction

    function automatic logic fault_expected(input logic [1:0] lo, input bus_acc_t ac,
                                            input logic wr);
        return wr || (lo[0] && ac != ACC_1B) || (lo == 2'd2 && ac == ACC_4B);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("[ERROR] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, want);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("t=%0t %s", $time, what);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic write_cfg(input logic [7:0] cmd, input logic [3:0] dcnt, input logic ddir,
                             input logic [2:0] mode);
        logic [15:0] word;
        word = {cmd, dcnt, ddir, mode};
        @(negedge clk);
        csr_we    = 1'b1;
        csr_wdata = word;
        cfg_cmd   = cmd;
        cfg_dcnt  = dcnt;
        cfg_mode  = mode;
        @(negedge clk);
        csr_we = 1'b0;
        assert (csr_rdata == word) else report_mismatch("csr_rdata", csr_rdata, word);
    endtask

    task automatic issue_read(input logic [23:0] a, input bus_acc_t ac, input logic wr);
        int waited;
        waited = 0;
        @(negedge clk);
        addr      = a;
        acc       = ac;
        w_rb      = wr;
        req       = 1'b1;
        exp_fault = fault_expected(a[1:0], ac, wr);
        exp_rdata = expected_rdata(a, ac);
        exp_mask  = byte_mask(ac);
        pending   = !exp_fault;
        @(negedge clk);
        req = 1'b0;
        if (exp_fault) begin
            repeat (READ_LIMIT) begin  // no resp, flash stays deselected
                assert (csb === 1'b1) else report_mismatch("csb", csb, 32'd1);
                @(negedge clk);
            end
        end else begin
            while (pending) begin
                waited++;
                assert (waited < READ_LIMIT)
                    else report_failure("no resp within 1200 cycles of a valid read");
                @(negedge clk);
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            report_failure("timeout, the run went past its cycle limit");
        end
    end

    // compare fault at req, rdata at resp
    always @(posedge clk) begin
        if (rstn) begin
            if (req) begin
                assert (fault == exp_fault) else report_mismatch("fault", fault, exp_fault);
            end
            if (resp) begin
                assert (pending) else report_failure("resp seen with no read outstanding");
                assert ((rdata & exp_mask) == exp_rdata)
                    else report_mismatch("rdata", rdata & exp_mask, exp_rdata);
                assert (!cmd_bad) else report_failure("flash received a wrong command octet");
                assert (!dir_bad)
                    else report_failure("lane directions wrong while the flash was selected");
                pending = 1'b0;
            end
            if (resp_q) begin
                assert (csb === 1'b1) else report_mismatch("csb", csb, 32'd1);
            end
            resp_q = resp;
        end
    end

    initial begin
        bus_acc_t    ac;
        logic [23:0] a;
        void'($urandom(32'h7fec92bd));
        rstn      = 1'b0;
        addr      = '0;
        acc       = ACC_1B;
        w_rb      = 1'b0;
        req       = 1'b0;
        csr_we    = 1'b0;
        csr_wdata = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rstn = 1'b1;
        assert (csb === 1'b1) else report_mismatch("csb", csb, 32'd1);
        assert (resp === 1'b0) else report_mismatch("resp", resp, 32'd0);
        assert (sclk === 1'b0) else report_mismatch("sclk", sclk, 32'd0);
        assert (csr_rdata === 16'h0) else report_mismatch("csr_rdata", csr_rdata, 32'd0);

        write_cfg(8'h03, 4'd0, 1'b0, 3'd0);
        repeat (10) issue_read(24'($urandom), ACC_1B, 1'b0);

        // every mode, dummy count walks through 0..15
        for (int m = 0; m < 7; m++) begin
            for (int i = 0; i < 8; i++) begin
                write_cfg(8'($urandom), 4'(m * 8 + i), 1'($urandom), 3'(m));
                ac = ($urandom & 1) ? ACC_4B : ACC_2B;
                a  = 24'($urandom);
                a  = (ac == ACC_4B) ? (a & 24'hff_fffc) : (a & 24'hff_fffe);
                issue_read(a, ac, 1'b0);
            end
        end

        write_cfg(8'h0b, 4'd8, 1'b1, 3'd0);
        issue_read(24'h000101, ACC_2B, 1'b0);
        issue_read(24'h000203, ACC_4B, 1'b0);
        issue_read(24'h000306, ACC_4B, 1'b0);
        issue_read(24'h000400, ACC_1B, 1'b1);
        issue_read(24'h000504, ACC_4B, 1'b1);
        issue_read(24'h000607, ACC_2B, 1'b0);
        issue_read(24'h000608, ACC_4B, 1'b0);  // still reads after faults

        repeat (4) @(negedge clk);
        $display("test passed");
        $finish;
    end

endmodule

//--- vlog.f
common/qspinor_bus_pkg.sv
common/qspinor_phy_pkg.sv
logic/qspinor_mode_csr.sv
qspinor_read/qspinor_read_seq.sv
logic/qspinor_shifter.sv
logic/qspinor_top.sv
tests/qspinor_flash_model.sv
tests/tb_qspinor.sv
